// ==== Makefile ====
# Verilator build and run of the hdmi init testbench

VERILATOR ?= verilator
TOP       ?= tb_hdmi_init
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
design/hdmi_init_pkg.sv
design/iic_bit_engine.sv
design/iic_txn_ctrl.sv
design/init_sequencer.sv
design/hdmi_init_top.sv
testbench/iic_slave_model.sv
testbench/hdmi_init_assertions.sv
testbench/tb_hdmi_init.sv

// ==== design/hdmi_init_pkg.sv ====
`default_nettype none

package hdmi_init_pkg;

    //////////////////////////////
    // widths with a meaning
    typedef logic [15:0] reg_addr_t;   // register address inside the tx chip
    typedef logic [7:0]  reg_data_t;   // register value
    typedef logic [6:0]  dev_addr_t;   // 7-bit i2c device address
    typedef logic [4:0]  entry_idx_t;  // init table index
    typedef logic [4:0]  err_cnt_t;    // failed entries, saturating

    //////////////////////////////
    // bus and retry constants
    localparam dev_addr_t DEV_ADDR       = 7'h59;  // 0xb2 as 8-bit write address
    localparam int        MAX_RETRY      = 3;      // attempts per transaction
    localparam int        RETRY_W        = $clog2(MAX_RETRY);
    localparam int        QUARTER_CYCLES = 5;      // clk cycles per scl quarter
    localparam int        TICK_W         = $clog2(QUARTER_CYCLES);

    // bit engine commands
    typedef enum logic [2:0] {
        OP_START,     // start or repeated start
        OP_STOP,
        OP_WRITE,     // byte out, slave ack in
        OP_RD_ACK,    // byte in, master ack
        OP_RD_NACK    // byte in, master nack
    } bit_op_t;

    //////////////////////////////
    // register init table
    localparam int INIT_LEN = 24;

    localparam reg_addr_t INIT_ADDR [INIT_LEN] = '{
        16'h1281, 16'h0016, 16'h0009, 16'h0007,  // clock and pll setup
        16'h0008, 16'h000a, 16'h0003, 16'h0004,
        16'h0005, 16'h0006, 16'h1206, 16'h120f,  // video timing
        16'h1210, 16'h1211, 16'h1212, 16'h1213,
        16'h1080, 16'h1084, 16'h1086, 16'h1090,  // hdmi packet setup
        16'h1091, 16'h10b0, 16'h10b1, 16'h1100   // output enable last
    };

    localparam reg_data_t INIT_DATA [INIT_LEN] = '{
        8'h04, 8'h04, 8'h20, 8'h09,
        8'hf0, 8'h30, 8'h53, 8'h00,
        8'h06, 8'h04, 8'h03, 8'h10,
        8'h00, 8'h0c, 8'h40, 8'h21,
        8'h01, 8'h1c, 8'h50, 8'h81,
        8'h02, 8'h0d, 8'h4d, 8'h01
    };

endpackage

`default_nettype wire

// ==== design/hdmi_init_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdmi_init_top (
    input  wire                     clk,
    input  wire                     rst_n,
    output wire                     init_done,
    output wire                     init_error,
    output wire hdmi_init_pkg::err_cnt_t err_count,
    output wire                     iic_scl,
    inout  wire                     iic_sda
);
    import hdmi_init_pkg::*;

    logic [1:0] rst_sync;      // release shifts in after two edges
    wire        sys_rst_n;
    wire        txn_valid, txn_read, txn_done, txn_nack;
    reg_addr_t  txn_addr;
    reg_data_t  txn_wdata, txn_rdata;
    wire        bit_go, bit_done, bit_ack;
    bit_op_t    bit_op;
    wire  [7:0] bit_wbyte, bit_rbyte;
    wire        sda_oe, sda_in;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rst_sync <= 2'b00;                  // assert at once
        else
            rst_sync <= {rst_sync[0], 1'b1};    // release synchronously
    end
    assign sys_rst_n = rst_sync[1];

    // open drain pad, board pull-up gives the high level
    assign iic_sda = sda_oe ? 1'b0 : 1'bz;
    assign sda_in  = iic_sda;

    init_sequencer u_seq (.clk, .rst_n(sys_rst_n), .txn_done, .txn_nack, .txn_rdata,
        .txn_valid, .txn_read, .txn_addr, .txn_wdata, .init_done, .init_error, .err_count);

    iic_txn_ctrl u_txn (.clk, .rst_n(sys_rst_n), .txn_valid, .txn_read, .txn_addr, .txn_wdata,
        .bit_done, .bit_ack, .bit_rbyte, .txn_done, .txn_nack, .txn_rdata, .bit_go, .bit_op,
        .bit_wbyte);

    iic_bit_engine u_bit (.clk, .rst_n(sys_rst_n), .bit_go, .bit_op, .bit_wbyte, .sda_in,
        .bit_done, .bit_ack, .bit_rbyte, .iic_scl, .sda_oe);

endmodule

`default_nettype wire

// ==== design/iic_bit_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module iic_bit_engine (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         bit_go,
    input  wire hdmi_init_pkg::bit_op_t bit_op,
    input  wire [7:0]                   bit_wbyte,
    input  wire                         sda_in,
    output logic                        bit_done,
    output logic                        bit_ack,
    output logic [7:0]                  bit_rbyte,
    output logic                        iic_scl,
    output logic                        sda_oe
);
    import hdmi_init_pkg::*;

    logic              busy;
    bit_op_t           op_q;
    logic [1:0]        qtr;       // quarter within the current bit
    logic [3:0]        bit_cnt;   // 0..7 data, 8 ack
    logic [TICK_W-1:0] tick;
    logic [7:0]        tx_sr;     // msb goes out first
    logic              qtr_end;
    logic              is_byte;
    logic              last_q;
    logic [1:0]        next_q;
    logic [3:0]        next_b;
    logic              next_tx;

    // scl level and sda pull for one quarter
    function automatic logic [1:0] quarter_lines(bit_op_t op, logic [1:0] q,
                                                 logic [3:0] b, logic tx);
        logic scl_hi;
        logic pull;
        scl_hi = (q == 2'd1) || (q == 2'd2);    // high in the middle quarters
        case (op)
            OP_START:  pull = q[1];             // sda falls while scl high
            OP_STOP:
            begin
                scl_hi = (q != 2'd0);
                pull   = !q[1];                 // sda rises while scl high
            end
            OP_WRITE:  pull = (b < 4'd8) && !tx; // ack bit left to the slave
            OP_RD_ACK: pull = (b == 4'd8);
            default:   pull = 1'b0;             // nack, line released
        endcase
        return {scl_hi, pull};
    endfunction

    //////////////////////////////
    // quarter sequencing
    always_comb
    begin
        qtr_end = busy && (tick == TICK_W'(QUARTER_CYCLES - 1));
        is_byte = op_q inside {OP_WRITE, OP_RD_ACK, OP_RD_NACK};
        last_q  = (qtr == 2'd3) && (!is_byte || (bit_cnt == 4'd8));
        next_q  = qtr + 2'd1;
        next_b  = (qtr == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;
        next_tx = (qtr == 2'd3) ? tx_sr[6] : tx_sr[7];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            op_q     <= OP_STOP;
            qtr      <= '0;
            bit_cnt  <= '0;
            tick     <= '0;
            bit_done <= 1'b0;
            iic_scl  <= 1'b1;                   // bus released
            sda_oe   <= 1'b0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (!busy)
            begin
                if (bit_go)
                begin
                    busy    <= 1'b1;
                    op_q    <= bit_op;
                    qtr     <= '0;
                    bit_cnt <= '0;
                    tick    <= '0;
                    {iic_scl, sda_oe} <= quarter_lines(bit_op, 2'd0, 4'd0, bit_wbyte[7]);
                end
            end
            else if (!qtr_end)
                tick <= tick + 1'b1;
            else
            begin
                tick <= '0;
                if (last_q)
                begin
                    busy     <= 1'b0;           // lines hold their last level
                    bit_done <= 1'b1;
                end
                else
                begin
                    qtr     <= next_q;
                    bit_cnt <= next_b;
                    {iic_scl, sda_oe} <= quarter_lines(op_q, next_q, next_b, next_tx);
                end
            end
        end
    end

    // data shift registers
    always_ff @(posedge clk)
    begin
        if (!busy && bit_go)
            tx_sr <= bit_wbyte;
        else if (qtr_end && (qtr == 2'd3))
            tx_sr <= {tx_sr[6:0], 1'b0};
        if (qtr_end && (qtr == 2'd1) && is_byte)
        begin
            if (bit_cnt < 4'd8)
                bit_rbyte <= {bit_rbyte[6:0], sda_in};  // sample mid scl high
            else
                bit_ack <= (op_q == OP_WRITE) ? !sda_in : 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/iic_txn_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module iic_txn_ctrl (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        txn_valid,
    input  wire                        txn_read,
    input  wire hdmi_init_pkg::reg_addr_t  txn_addr,
    input  wire hdmi_init_pkg::reg_data_t  txn_wdata,
    input  wire                        bit_done,
    input  wire                        bit_ack,
    input  wire [7:0]                  bit_rbyte,
    output logic                       txn_done,
    output logic                       txn_nack,
    output hdmi_init_pkg::reg_data_t   txn_rdata,
    output logic                       bit_go,
    output hdmi_init_pkg::bit_op_t     bit_op,
    output logic [7:0]                 bit_wbyte
);
    import hdmi_init_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_DEVW,     // device address, write bit
        ST_ADDRH,
        ST_ADDRL,
        ST_WDATA,
        ST_RSTART,   // repeated start before the read
        ST_DEVR,     // device address, read bit
        ST_RDATA,    // single byte, master nack
        ST_STOP
    } txn_state_t;

    txn_state_t state;
    txn_state_t next_state;
    logic       pend;        // bit engine credit is out
    logic       acked_step;  // step expects a slave ack
    logic       rd_q;
    reg_addr_t  addr_q;
    reg_data_t  wdata_q;

    //////////////////////////////
    // step decode
    always_comb
    begin
        acked_step = state inside {ST_DEVW, ST_ADDRH, ST_ADDRL, ST_WDATA, ST_DEVR};
        case (state)
            ST_START:  next_state = ST_DEVW;
            ST_DEVW:   next_state = ST_ADDRH;
            ST_ADDRH:  next_state = ST_ADDRL;
            ST_ADDRL:  next_state = rd_q ? ST_RSTART : ST_WDATA;
            ST_WDATA:  next_state = ST_STOP;
            ST_RSTART: next_state = ST_DEVR;
            ST_DEVR:   next_state = ST_RDATA;
            ST_RDATA:  next_state = ST_STOP;
            default:   next_state = ST_IDLE;   // stop ends the attempt
        endcase
        case (state)
            ST_START, ST_RSTART: bit_op = OP_START;
            ST_STOP:             bit_op = OP_STOP;
            ST_RDATA:            bit_op = OP_RD_NACK;
            default:             bit_op = OP_WRITE;
        endcase
        case (state)
            ST_DEVW:  bit_wbyte = {DEV_ADDR, 1'b0};
            ST_DEVR:  bit_wbyte = {DEV_ADDR, 1'b1};
            ST_ADDRH: bit_wbyte = addr_q[15:8];      // high byte first
            ST_ADDRL: bit_wbyte = addr_q[7:0];
            ST_WDATA: bit_wbyte = wdata_q;
            default:  bit_wbyte = 8'hff;
        endcase
    end

    // one bit command per step, only while the credit is home
    assign bit_go = (state != ST_IDLE) && !pend;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_IDLE;
            pend     <= 1'b0;
            txn_done <= 1'b0;
            txn_nack <= 1'b0;
        end
        else
        begin
            txn_done <= 1'b0;
            if (bit_go)
                pend <= 1'b1;
            else if (bit_done)
                pend <= 1'b0;                   // credit returned
            if (state == ST_IDLE)
            begin
                if (txn_valid)
                begin
                    txn_nack <= 1'b0;
                    state    <= ST_START;
                end
            end
            else if (bit_done)
            begin
                if (acked_step && !bit_ack)
                begin
                    txn_nack <= 1'b1;           // abort, still close with a stop
                    state    <= ST_STOP;
                end
                else
                    state <= next_state;
                if (state == ST_STOP)
                    txn_done <= 1'b1;           // nack and rdata valid now
            end
        end
    end

    // request payload and read data
    always_ff @(posedge clk)
    begin
        if (txn_valid && (state == ST_IDLE))
        begin
            rd_q    <= txn_read;
            addr_q  <= txn_addr;
            wdata_q <= txn_wdata;
        end
        if (bit_done && (state == ST_RDATA))
            txn_rdata <= bit_rbyte;
    end

endmodule

`default_nettype wire

// ==== design/init_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module init_sequencer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       txn_done,
    input  wire                       txn_nack,
    input  wire hdmi_init_pkg::reg_data_t txn_rdata,
    output logic                      txn_valid,
    output logic                      txn_read,
    output hdmi_init_pkg::reg_addr_t  txn_addr,
    output hdmi_init_pkg::reg_data_t  txn_wdata,
    output logic                      init_done,
    output logic                      init_error,
    output hdmi_init_pkg::err_cnt_t   err_count
);
    import hdmi_init_pkg::*;

    typedef enum logic [1:0] {
        SQ_ISSUE,   // spend the credit
        SQ_WAIT,    // credit out, wait for done
        SQ_DONE     // table finished, bus left idle
    } sq_state_t;

    sq_state_t          state;
    entry_idx_t         idx;         // current table entry
    logic [RETRY_W-1:0] attempt;     // attempts used so far, minus one
    logic               credit;      // one transaction in flight at most
    logic               last_try;
    logic               txn_fail;
    logic               entry_end;
    err_cnt_t           err_next;

    // table entry drives the request payload
    assign txn_addr  = INIT_ADDR[idx];
    assign txn_wdata = INIT_DATA[idx];

    //////////////////////////////
    // outcome of the returning transaction
    always_comb
    begin
        last_try  = (attempt == RETRY_W'(MAX_RETRY - 1));
        txn_fail  = txn_nack ? last_try
                             : (txn_read && (txn_rdata != INIT_DATA[idx]));  // read-back mismatch
        entry_end = txn_fail || (txn_read && !txn_nack);  // failed, or read-back finished
        err_next  = (txn_fail && (err_count != '1)) ? err_count + 1'b1 : err_count;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= SQ_ISSUE;
            idx        <= '0;
            attempt    <= '0;
            credit     <= 1'b1;      // credit held after reset
            txn_valid  <= 1'b0;
            txn_read   <= 1'b0;
            init_done  <= 1'b0;
            init_error <= 1'b0;
            err_count  <= '0;
        end
        else
        begin
            txn_valid <= 1'b0;                  // one cycle pulse
            case (state)
                SQ_ISSUE:
                begin
                    if (credit)
                    begin
                        txn_valid <= 1'b1;
                        credit    <= 1'b0;
                        state     <= SQ_WAIT;
                    end
                end
                SQ_WAIT:
                begin
                    if (txn_done)
                    begin
                        credit    <= 1'b1;      // credit back
                        err_count <= err_next;
                        if (!entry_end)
                        begin
                            if (txn_nack)
                                attempt <= attempt + 1'b1;  // retry same transaction
                            else
                            begin
                                attempt  <= '0;
                                txn_read <= 1'b1;           // write ok, now read back
                            end
                            state <= SQ_ISSUE;
                        end
                        else
                        begin
                            attempt  <= '0;
                            txn_read <= 1'b0;
                            if (idx == entry_idx_t'(INIT_LEN - 1))
                            begin
                                init_done  <= 1'b1;          // sticky until reset
                                init_error <= (err_next != '0);
                                state      <= SQ_DONE;
                            end
                            else
                            begin
                                idx   <= idx + 1'b1;
                                state <= SQ_ISSUE;
                            end
                        end
                    end
                end
                default: state <= SQ_DONE;      // stay finished
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== testbench/hdmi_init_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdmi_init_assertions (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         scl,
    input wire                         sda,
    input wire                         bit_go,
    input wire hdmi_init_pkg::bit_op_t bit_op,
    input wire                         bit_done,
    input wire                         txn_valid,
    input wire                         txn_done,
    input wire                         init_done
);
    import hdmi_init_pkg::*;

    logic    txn_credit;
    logic    bit_credit;
    bit_op_t cur_op;
    wire     edge_op = (cur_op == OP_START) || (cur_op == OP_STOP);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            txn_credit <= 1'b1;
            bit_credit <= 1'b1;
            cur_op     <= OP_STOP;     // idle bus counts as after stop
        end
        else
        begin
            if (txn_valid)
                txn_credit <= 1'b0;
            else if (txn_done)
                txn_credit <= 1'b1;
            if (bit_go)
            begin
                bit_credit <= 1'b0;
                cur_op     <= bit_op;
            end
            else if (bit_done)
                bit_credit <= 1'b1;
        end
    end

    //////////////////////////////
    sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (scl && $past(scl) && !edge_op) |-> $stable(sda))
        else $error("sda changed while scl high");

    txn_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        txn_valid |-> txn_credit)
        else $error("txn_valid without credit");

    bit_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        bit_go |-> bit_credit)
        else $error("bit_go while a bit operation is outstanding");

    done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done)
        else $error("init_done fell without reset");

endmodule

bind hdmi_init_top hdmi_init_assertions u_assert (
    .clk(clk), .rst_n(sys_rst_n), .scl(iic_scl), .sda(iic_sda), .bit_go(bit_go),
    .bit_op(bit_op), .bit_done(bit_done), .txn_valid(txn_valid), .txn_done(txn_done),
    .init_done(init_done));

`default_nettype wire

// ==== testbench/iic_slave_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module iic_slave_model (
    input  wire clk,
    input  wire rst_n,
    input  wire scl,
    inout  wire sda
);
    import hdmi_init_pkg::*;

    logic [31:0] lfsr_q = 32'd70095;    // not reloaded on reset, new draws per run
    logic        drawn = 1'b0;
    logic        sda_pull;
    logic        scl_q, sda_q;
    logic        in_txn, skip_fall, nack_now, last_nack;
    logic        rd_mode, sending, acked, got_data;
    logic [3:0]  bit_cnt;               // 0..7 data, 8 ack
    logic [1:0]  seg_byte;              // byte index since last start
    logic [7:0]  shift, tx;
    reg_addr_t   addr;
    reg_data_t   wdata;
    int          attempt_no;
    reg_data_t   mem [reg_addr_t];
    reg_data_t   mask_of [reg_addr_t];  // stuck bits per register

    //////////////////////////////
    // logs read by the testbench model
    logic        dec_q [$];             // nack decision per attempt
    reg_addr_t   wr_addr_q [$];
    reg_data_t   wr_data_q [$];
    int          wr_att_q [$];
    reg_data_t   entry_mask [INIT_LEN];

    assign sda = sda_pull ? 1'b0 : 1'bz;    // open drain

    // galois lfsr, one step per bit taken
    function automatic logic [7:0] take_bits(int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v      = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    always @(posedge clk)
    begin
        reg_data_t m;
        if (!rst_n)
        begin
            if (!drawn)
            begin
                dec_q.delete();
                wr_addr_q.delete();
                wr_data_q.delete();
                wr_att_q.delete();
                mem.delete();
                for (int i = 0; i < INIT_LEN; i++)
                begin
                    m = take_bits(8);
                    m = (take_bits(3) == 8'd7) ? m : 8'h00;   // mostly zero
                    mask_of[INIT_ADDR[i]] = m;
                    entry_mask[i]         = m;
                end
            end
            drawn      = 1'b1;
            in_txn     = 1'b0;
            skip_fall  = 1'b0;
            last_nack  = 1'b0;
            attempt_no = 0;
            sending    = 1'b0;
            got_data   = 1'b0;
            scl_q      = 1'b1;
            sda_q      = 1'b1;
            sda_pull  <= 1'b0;
        end
        else
        begin
            drawn = 1'b0;
            if (scl && scl_q && sda_q && !sda)             // start or repeated start
            begin
                if (!in_txn)
                begin
                    nack_now   = (take_bits(3) == 8'd7);
                    attempt_no = (last_nack && (attempt_no < MAX_RETRY))
                               ? attempt_no + 1 : 1;        // new transaction after last retry
                    last_nack  = nack_now;
                    dec_q.push_back(nack_now);
                    got_data   = 1'b0;
                end
                in_txn    = 1'b1;
                skip_fall = 1'b1;                           // start ends with scl fall
                bit_cnt   = 4'd0;
                seg_byte  = 2'd0;
                rd_mode   = 1'b0;
                sending   = 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)        // stop
            begin
                if (got_data)
                begin
                    mem[addr] = wdata;
                    wr_addr_q.push_back(addr);
                    wr_data_q.push_back(wdata);
                    wr_att_q.push_back(attempt_no);
                end
                got_data  = 1'b0;
                in_txn    = 1'b0;
                sending   = 1'b0;
                sda_pull <= 1'b0;
            end
            else if (in_txn && scl && !scl_q && !sending)
                shift = {shift[6:0], sda};                  // sample on scl rise
            else if (in_txn && !scl && scl_q)
            begin
                if (skip_fall)
                    skip_fall = 1'b0;
                else if (bit_cnt < 4'd7)
                begin
                    bit_cnt = bit_cnt + 4'd1;
                    if (sending)
                    begin
                        tx        = {tx[6:0], 1'b0};
                        sda_pull <= !tx[7];
                    end
                end
                else if (bit_cnt == 4'd7)
                begin
                    bit_cnt = 4'd8;
                    if (sending)
                        sda_pull <= 1'b0;                   // master acks or nacks
                    else
                    begin
                        acked = 1'b1;
                        case (seg_byte)
                            2'd0:
                            begin
                                acked   = (shift[7:1] == DEV_ADDR) && !nack_now;
                                rd_mode = shift[0];
                            end
                            2'd1:    addr[15:8] = shift;
                            2'd2:    addr[7:0]  = shift;
                            default:
                            begin
                                wdata    = shift;
                                got_data = 1'b1;
                            end
                        endcase
                        sda_pull <= acked;
                    end
                end
                else
                begin
                    bit_cnt   = 4'd0;
                    sda_pull <= 1'b0;
                    if (sending)
                        sending = 1'b0;
                    else
                    begin
                        if (rd_mode && acked)
                        begin
                            sending   = 1'b1;
                            tx        = mem[addr] | mask_of[addr];  // stuck bits read high
                            sda_pull <= !tx[7];
                        end
                        seg_byte = seg_byte + 2'd1;
                    end
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_hdmi_init.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hdmi_init;
    import hdmi_init_pkg::*;

    localparam int     CLK_NS      = 20;
    localparam int     RUNS        = 2;
    localparam int     IDLE_CYCLES = 200;
    localparam int     RUN_CYCLES  = INIT_LEN * 2 * MAX_RETRY * 6 * 40 * QUARTER_CYCLES;
    localparam longint WATCHDOG_NS = longint'(RUNS) * longint'(RUN_CYCLES + 2000) * CLK_NS;

    logic     clk   = 1'b0;
    logic     rst_n = 1'b0;
    wire      init_done;
    wire      init_error;
    wire      iic_scl;
    wire      iic_sda;
    err_cnt_t err_count;

    always #(CLK_NS / 2) clk = ~clk;
    pullup (iic_sda);                               // board pull-up

    hdmi_init_top dut (.clk(clk), .rst_n(rst_n), .init_done(init_done),
        .init_error(init_error), .err_count(err_count), .iic_scl(iic_scl), .iic_sda(iic_sda));

    iic_slave_model slave (.clk(clk), .rst_n(rst_n), .scl(iic_scl), .sda(iic_sda));

    task automatic check_value(string name, int expected, int actual);
        assert (expected == actual)
        else
        begin
            $display("error %s: expected %0h actual %0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_reset_outputs(string name);
        check_value({name, " init_done"}, 0, int'(init_done));
        check_value({name, " init_error"}, 0, int'(init_error));
        check_value({name, " err_count"}, 0, int'(err_count));
        check_value({name, " scl"}, 1, int'(iic_scl));
        check_value({name, " sda"}, 1, int'(iic_sda));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            check_reset_outputs("reset hold");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs("reset release");
    endtask

    // walk the slave's decisions for one transaction
    task automatic take_attempts(inout int di, output logic ok, output int used);
        ok   = 1'b0;
        used = 0;
        while (!ok && (used < MAX_RETRY))
        begin
            check_value("attempt seen by slave", 1, int'(di < slave.dec_q.size()));
            ok   = !slave.dec_q[di];
            di   = di + 1;
            used = used + 1;
        end
    endtask

    //////////////////////////////
    // reference model of the whole table
    task automatic check_results();
        int   di;
        int   wi;
        int   errs;
        int   used;
        logic ok;
        logic fail;
        di   = 0;
        wi   = 0;
        errs = 0;
        for (int e = 0; e < INIT_LEN; e++)
        begin
            fail = 1'b0;
            take_attempts(di, ok, used);            // write
            if (!ok)
                fail = 1'b1;                        // no read after failed write
            else
            begin
                check_value("write logged", 1, int'(wi < slave.wr_addr_q.size()));
                check_value("write address", int'(INIT_ADDR[e]), int'(slave.wr_addr_q[wi]));
                check_value("write data", int'(INIT_DATA[e]), int'(slave.wr_data_q[wi]));
                check_value("write attempt", used, slave.wr_att_q[wi]);
                wi = wi + 1;
                take_attempts(di, ok, used);        // read back
                if (!ok)
                    fail = 1'b1;
                else if ((INIT_DATA[e] | slave.entry_mask[e]) != INIT_DATA[e])
                    fail = 1'b1;                    // stuck bit visible
            end
            if (fail && (errs < int'(err_cnt_t'('1))))
                errs = errs + 1;
        end
        check_value("attempt count", di, slave.dec_q.size());
        check_value("write count", wi, slave.wr_addr_q.size());
        check_value("err_count", errs, int'(err_count));
        check_value("init_error", int'(errs != 0), int'(init_error));
    endtask

    task automatic check_idle_bus();
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            check_value("idle init_done", 1, int'(init_done));
            check_value("idle scl", 1, int'(iic_scl));
            check_value("idle sda", 1, int'(iic_sda));
        end
    endtask

    initial
    begin
        for (int r = 0; r < RUNS; r++)
        begin
            apply_reset();
            while (!init_done)
                @(negedge clk);                     // watchdog bounds this
            check_results();
            check_idle_bus();
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: init sequence did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire
